// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module raster_tb \
    && ./obj_dir/Vraster_tb | tee /dev/stderr | grep -q "Finished with no errors" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: src.f
src/raster_pkg.sv
src/tri_queue_if.sv
src/triangle_setup.sv
src/setup_fifo.sv
src/scan_converter.sv
src/raster_top.sv
tb/raster_checker.sv
tb/raster_tb.sv

// File: src/raster_pkg.sv
`default_nettype none

package raster_pkg;

    // Tile geometry
    localparam int FB_W = 16;
    localparam int FB_H = 8;
    localparam int FB_ADDR_W = 7;
    localparam int BOX_X_W = $clog2(FB_W);
    localparam int BOX_Y_W = $clog2(FB_H);

    localparam int COORD_W = 8;
    localparam int DEPTH_W = 16;
    localparam int EDGE_W = 24;

    // Reciprocal is floor(2^16 / area), so area 1 needs the extra bit
    localparam int RECIP_SHIFT = 16;
    localparam int RECIP_W = RECIP_SHIFT + 1;
    localparam int ACC_W = 64;

    typedef struct packed {
        logic signed [COORD_W-1:0] x;
        logic signed [COORD_W-1:0] y;
        logic [DEPTH_W-1:0] z;
    } vertex_t;

    typedef struct packed {
        logic [BOX_X_W-1:0] min_x;
        logic [BOX_X_W-1:0] max_x;
        logic [BOX_Y_W-1:0] min_y;
        logic [BOX_Y_W-1:0] max_y;
        // Edge values at the top-left corner of the box
        logic signed [EDGE_W-1:0] e0;
        logic signed [EDGE_W-1:0] e1;
        logic signed [EDGE_W-1:0] e2;
        logic signed [EDGE_W-1:0] e0_dx;
        logic signed [EDGE_W-1:0] e0_dy;
        logic signed [EDGE_W-1:0] e1_dx;
        logic signed [EDGE_W-1:0] e1_dy;
        logic signed [EDGE_W-1:0] e2_dx;
        logic signed [EDGE_W-1:0] e2_dy;
        logic signed [ACC_W-1:0] z;
        logic signed [ACC_W-1:0] z_dx;
        logic signed [ACC_W-1:0] z_dy;
    } tri_setup_t;

endpackage

`default_nettype wire

// File: src/raster_top.sv
`timescale 1ns/100ps
`default_nettype none

module raster_top #(
    parameter int RECIP_SIZE = 1024,
    parameter int FIFO_DEPTH = 4
) (
    input logic clk,
    input logic rst,
    input logic tri_valid,
    input logic signed [raster_pkg::COORD_W-1:0] x0,
    input logic signed [raster_pkg::COORD_W-1:0] y0,
    input logic [raster_pkg::DEPTH_W-1:0] z0,
    input logic signed [raster_pkg::COORD_W-1:0] x1,
    input logic signed [raster_pkg::COORD_W-1:0] y1,
    input logic [raster_pkg::DEPTH_W-1:0] z1,
    input logic signed [raster_pkg::COORD_W-1:0] x2,
    input logic signed [raster_pkg::COORD_W-1:0] y2,
    input logic [raster_pkg::DEPTH_W-1:0] z2,
    output logic busy,
    output logic culled,
    output logic pix_write,
    output logic [raster_pkg::FB_ADDR_W-1:0] fb_addr,
    output logic [raster_pkg::DEPTH_W-1:0] depth,
    output logic tri_done
);

    import raster_pkg::*;

    vertex_t v0, v1, v2;

    assign v0 = {x0, y0, z0};
    assign v1 = {x1, y1, z1};
    assign v2 = {x2, y2, z2};

    tri_queue_if #(.T(tri_setup_t)) q_if ();

    triangle_setup #(
        .RECIP_SIZE(RECIP_SIZE)
    ) u_setup (
        .clk(clk),
        .rst(rst),
        .tri_valid(tri_valid),
        .v0(v0),
        .v1(v1),
        .v2(v2),
        .busy(busy),
        .culled(culled),
        .q(q_if.producer)
    );

    setup_fifo #(
        .T(tri_setup_t),
        .DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk(clk),
        .rst(rst),
        .q(q_if.buffer)
    );

    scan_converter u_scan (
        .clk(clk),
        .rst(rst),
        .q(q_if.consumer),
        .pix_write(pix_write),
        .fb_addr(fb_addr),
        .depth(depth),
        .tri_done(tri_done)
    );

endmodule

`default_nettype wire

// File: src/scan_converter.sv
`timescale 1ns/100ps
`default_nettype none

module scan_converter (
    input logic clk,
    input logic rst,
    tri_queue_if.consumer q,
    output logic pix_write,
    output logic [raster_pkg::FB_ADDR_W-1:0] fb_addr,
    output logic [raster_pkg::DEPTH_W-1:0] depth,
    output logic tri_done
);

    import raster_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_DRAW, S_DONE} state_t;

    state_t state;
    tri_setup_t rec;
    logic [BOX_X_W-1:0] x;
    logic [BOX_Y_W-1:0] y;
    logic [FB_ADDR_W-1:0] addr;
    logic signed [EDGE_W-1:0] e0, e1, e2;
    logic signed [EDGE_W-1:0] e0_row, e1_row, e2_row;
    logic signed [ACC_W-1:0] z_acc, z_row;
    logic row_end, last_pix;

    function automatic logic [FB_ADDR_W-1:0] pix_addr(
        input logic [BOX_X_W-1:0] px,
        input logic [BOX_Y_W-1:0] py
    );
        return FB_ADDR_W'(int'(py) * FB_W + int'(px));
    endfunction

    assign row_end = (x == rec.max_x);
    assign last_pix = row_end && (y == rec.max_y);

    assign q.pop = (state == S_IDLE) && !q.empty;
    assign pix_write = (state == S_DRAW) && (e0 > 0) && (e1 > 0) && (e2 > 0);
    assign fb_addr = addr;
    assign depth = z_acc[RECIP_SHIFT +: DEPTH_W];
    assign tri_done = (state == S_DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (!q.empty) state <= S_DRAW;
                S_DRAW: if (last_pix) state <= S_DONE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (q.pop) begin
            rec <= q.rdata;
            x <= q.rdata.min_x;
            y <= q.rdata.min_y;
            addr <= pix_addr(q.rdata.min_x, q.rdata.min_y);
            e0 <= q.rdata.e0;
            e1 <= q.rdata.e1;
            e2 <= q.rdata.e2;
            e0_row <= q.rdata.e0;
            e1_row <= q.rdata.e1;
            e2_row <= q.rdata.e2;
            z_acc <= q.rdata.z;
            z_row <= q.rdata.z;
        end else if (state == S_DRAW) begin
            if (!row_end) begin
                x <= x + 1'b1;
                addr <= addr + 1'b1;
                e0 <= e0 + rec.e0_dx;
                e1 <= e1 + rec.e1_dx;
                e2 <= e2 + rec.e2_dx;
                z_acc <= z_acc + rec.z_dx;
            end else begin
                // Next row restarts from the row-start values stepped in y
                x <= rec.min_x;
                y <= y + 1'b1;
                addr <= pix_addr(rec.min_x, y + 1'b1);
                e0 <= e0_row + rec.e0_dy;
                e1 <= e1_row + rec.e1_dy;
                e2 <= e2_row + rec.e2_dy;
                e0_row <= e0_row + rec.e0_dy;
                e1_row <= e1_row + rec.e1_dy;
                e2_row <= e2_row + rec.e2_dy;
                z_acc <= z_row + rec.z_dy;
                z_row <= z_row + rec.z_dy;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/setup_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module setup_fifo #(
    parameter type T = logic,
    parameter int DEPTH = 4
) (
    input logic clk,
    input logic rst,
    tri_queue_if.buffer q
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T mem [DEPTH];
    logic [AW-1:0] wr_ptr, rd_ptr;
    logic [CW-1:0] count;
    logic do_push, do_pop;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_push = q.push && !q.full;
    assign do_pop = q.pop && !q.empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= q.wdata;
    end

    assign q.full = (count == CW'(DEPTH));
    assign q.empty = (count == '0);
    assign q.rdata = mem[rd_ptr];

endmodule

`default_nettype wire

// File: src/tri_queue_if.sv
`timescale 1ns/100ps
`default_nettype none

interface tri_queue_if #(
    parameter type T = logic
);

    logic push;
    T wdata;
    logic full;
    logic pop;
    T rdata;
    logic empty;

    modport producer(output push, output wdata, input full);

    // Show-ahead: rdata is the head entry whenever empty is low
    modport buffer(
        input push, input wdata, input pop,
        output full, output rdata, output empty
    );

    modport consumer(output pop, input rdata, input empty);

endinterface

`default_nettype wire

// File: src/triangle_setup.sv
`timescale 1ns/100ps
`default_nettype none

module triangle_setup #(
    parameter int RECIP_SIZE = 1024
) (
    input logic clk,
    input logic rst,
    input logic tri_valid,
    input raster_pkg::vertex_t v0,
    input raster_pkg::vertex_t v1,
    input raster_pkg::vertex_t v2,
    output logic busy,
    output logic culled,
    tri_queue_if.producer q
);

    import raster_pkg::*;

    localparam int RECIP_AW = (RECIP_SIZE > 1) ? $clog2(RECIP_SIZE) : 1;
    localparam logic signed [COORD_W-1:0] X_LAST = COORD_W'(FB_W - 1);
    localparam logic signed [COORD_W-1:0] Y_LAST = COORD_W'(FB_H - 1);

    typedef enum logic [2:0] {S_IDLE, S_BOX, S_LOOKUP, S_PLANE, S_PUSH} state_t;

    state_t state;
    vertex_t vr0, vr1, vr2;
    tri_setup_t rec;
    logic [RECIP_W-1:0] recip_rom [RECIP_SIZE];
    logic [RECIP_W-1:0] recip;
    logic signed [EDGE_W-1:0] area;
    logic cull;
    logic signed [ACC_W-1:0] zsum, zsum_dx, zsum_dy;

    logic signed [COORD_W-1:0] lo_x, hi_x, lo_y, hi_y;
    logic [BOX_X_W-1:0] box_x0, box_x1;
    logic [BOX_Y_W-1:0] box_y0, box_y1;
    logic signed [EDGE_W-1:0] cx, cy, area_c;
    logic miss;
    logic signed [DEPTH_W:0] za, zb, zc;

    function automatic logic signed [COORD_W-1:0] min3(
        input logic signed [COORD_W-1:0] a,
        input logic signed [COORD_W-1:0] b,
        input logic signed [COORD_W-1:0] c
    );
        logic signed [COORD_W-1:0] m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic logic signed [COORD_W-1:0] max3(
        input logic signed [COORD_W-1:0] a,
        input logic signed [COORD_W-1:0] b,
        input logic signed [COORD_W-1:0] c
    );
        logic signed [COORD_W-1:0] m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // Edge from a to b evaluated at (px, py)
    function automatic logic signed [EDGE_W-1:0] edge_fn(
        input vertex_t a,
        input vertex_t b,
        input logic signed [EDGE_W-1:0] px,
        input logic signed [EDGE_W-1:0] py
    );
        logic signed [EDGE_W-1:0] ax, ay, bx, by;
        ax = a.x;
        ay = a.y;
        bx = b.x;
        by = b.y;
        return (px - ax) * (by - ay) - (py - ay) * (bx - ax);
    endfunction

    initial begin
        recip_rom[0] = '0;
        for (int i = 1; i < RECIP_SIZE; i++) begin
            recip_rom[i] = RECIP_W'((1 << RECIP_SHIFT) / i);
        end
    end

    always_comb begin
        lo_x = min3(vr0.x, vr1.x, vr2.x);
        hi_x = max3(vr0.x, vr1.x, vr2.x);
        lo_y = min3(vr0.y, vr1.y, vr2.y);
        hi_y = max3(vr0.y, vr1.y, vr2.y);
        miss = (hi_x < 0) || (lo_x > X_LAST) || (hi_y < 0) || (lo_y > Y_LAST);
        // Clamped bounds only matter when the box overlaps the tile
        box_x0 = (lo_x < 0) ? '0 : lo_x[BOX_X_W-1:0];
        box_x1 = (hi_x > X_LAST) ? BOX_X_W'(FB_W - 1) : hi_x[BOX_X_W-1:0];
        box_y0 = (lo_y < 0) ? '0 : lo_y[BOX_Y_W-1:0];
        box_y1 = (hi_y > Y_LAST) ? BOX_Y_W'(FB_H - 1) : hi_y[BOX_Y_W-1:0];
        cx = EDGE_W'(box_x0);
        cy = EDGE_W'(box_y0);
        area_c = edge_fn(vr0, vr1, vr2.x, vr2.y);
    end

    assign za = {1'b0, vr0.z};
    assign zb = {1'b0, vr1.z};
    assign zc = {1'b0, vr2.z};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (tri_valid) state <= S_BOX;
                S_BOX: state <= S_LOOKUP;
                S_LOOKUP: state <= cull ? S_IDLE : S_PLANE;
                S_PLANE: state <= S_PUSH;
                // Hold the record while the queue is full
                S_PUSH: if (!q.full) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                vr0 <= v0;
                vr1 <= v1;
                vr2 <= v2;
            end
            S_BOX: begin
                rec.min_x <= box_x0;
                rec.max_x <= box_x1;
                rec.min_y <= box_y0;
                rec.max_y <= box_y1;
                rec.e0 <= edge_fn(vr1, vr2, cx, cy);
                rec.e1 <= edge_fn(vr2, vr0, cx, cy);
                rec.e2 <= edge_fn(vr0, vr1, cx, cy);
                rec.e0_dx <= vr2.y - vr1.y;
                rec.e0_dy <= vr1.x - vr2.x;
                rec.e1_dx <= vr0.y - vr2.y;
                rec.e1_dy <= vr2.x - vr0.x;
                rec.e2_dx <= vr1.y - vr0.y;
                rec.e2_dy <= vr0.x - vr1.x;
                area <= area_c;
                cull <= (area_c <= 0) || (area_c >= RECIP_SIZE) || miss;
            end
            S_LOOKUP: begin
                recip <= recip_rom[area[RECIP_AW-1:0]];
                zsum <= rec.e0 * za + rec.e1 * zb + rec.e2 * zc;
                zsum_dx <= rec.e0_dx * za + rec.e1_dx * zb + rec.e2_dx * zc;
                zsum_dy <= rec.e0_dy * za + rec.e1_dy * zb + rec.e2_dy * zc;
            end
            S_PLANE: begin
                rec.z <= zsum * $signed({1'b0, recip});
                rec.z_dx <= zsum_dx * $signed({1'b0, recip});
                rec.z_dy <= zsum_dy * $signed({1'b0, recip});
            end
            default: ;
        endcase
    end

    assign busy = (state != S_IDLE);
    assign culled = (state == S_LOOKUP) && cull;
    assign q.push = (state == S_PUSH) && !q.full;
    assign q.wdata = rec;

endmodule

`default_nettype wire

// File: tb/raster_checker.sv
`timescale 1ns/100ps
`default_nettype none

module raster_checker (
    input logic clk,
    input logic rst,
    input logic tri_valid,
    input logic busy,
    input logic pix_write,
    input logic tri_done,
    input logic push,
    input logic full
);

    no_pix_in_reset: assert property (@(posedge clk) rst |-> !pix_write)
        else $error("pix_write asserted during reset");

    pix_not_with_done: assert property (@(posedge clk) disable iff (rst)
        !(pix_write && tri_done))
        else $error("pix_write and tri_done in the same cycle");

    // Triangles are only offered while setup is idle
    valid_only_when_idle: assert property (@(posedge clk) disable iff (rst)
        busy |-> !tri_valid)
        else $error("tri_valid asserted while busy");

    no_push_when_full: assert property (@(posedge clk) disable iff (rst) full |-> !push)
        else $error("FIFO pushed while full");

endmodule

bind raster_top raster_checker u_checker (
    .clk(clk),
    .rst(rst),
    .tri_valid(tri_valid),
    .busy(busy),
    .pix_write(pix_write),
    .tri_done(tri_done),
    .push(q_if.push),
    .full(q_if.full)
);

`default_nettype wire

// File: tb/raster_tb.sv
`timescale 1ns/100ps
`default_nettype none

module raster_tb;

    import raster_pkg::*;

    localparam int RECIP_SIZE = 1024;
    localparam int FIFO_DEPTH = 4;
    localparam int CLK_PERIOD = 40;
    localparam int MAX_CYCLES = 40 * 140;
    localparam int NUM_RANDOM = 30;

    logic clk;
    logic rst;
    logic tri_valid;
    logic signed [COORD_W-1:0] x0, y0, x1, y1, x2, y2;
    logic [DEPTH_W-1:0] z0, z1, z2;
    logic busy, culled, pix_write, tri_done;
    logic [FB_ADDR_W-1:0] fb_addr;
    logic [DEPTH_W-1:0] depth;

    int exp_addr[$];
    longint exp_depth[$];
    int exp_tri_pix[$];
    int cycles, sent, drawn_exp, culled_exp, done_seen, culled_seen, pix_in_tri;
    bit fifo_was_full;

    raster_top #(
        .RECIP_SIZE(RECIP_SIZE),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) dut (
        .clk(clk), .rst(rst), .tri_valid(tri_valid),
        .x0(x0), .y0(y0), .z0(z0), .x1(x1), .y1(y1), .z1(z1),
        .x2(x2), .y2(y2), .z2(z2),
        .busy(busy), .culled(culled), .pix_write(pix_write),
        .fb_addr(fb_addr), .depth(depth), .tri_done(tri_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        stop_with_failure();
    endtask

    task automatic check_value(input string what, input longint got, input longint exp);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0d ns: %s, got %0d, expected %0d",
                     $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    function automatic vertex_t make_vertex(input int x, input int y, input int z);
        vertex_t v;
        v.x = COORD_W'(x);
        v.y = COORD_W'(y);
        v.z = DEPTH_W'(z);
        return v;
    endfunction

    function automatic vertex_t random_vertex();
        return make_vertex(int'($urandom_range(23)) - 4, int'($urandom_range(15)) - 4,
                           int'($urandom_range(16'hffff)));
    endfunction

    function automatic longint edge_at(input vertex_t a, input vertex_t b,
                                       input longint px, input longint py);
        longint ax, ay, bx, by;
        ax = a.x;
        ay = a.y;
        bx = b.x;
        by = b.y;
        return (px - ax) * (by - ay) - (py - ay) * (bx - ax);
    endfunction

    // Returns 1 for a drawn triangle and queues its covered pixels
    function automatic bit model_triangle(input vertex_t a, input vertex_t b, input vertex_t c);
        longint area, recip, w0, w1, w2, za, zb, zc, acc;
        int lo_x, hi_x, lo_y, hi_y, npix;
        lo_x = (a.x < b.x) ? a.x : b.x;
        lo_x = (c.x < lo_x) ? c.x : lo_x;
        hi_x = (a.x > b.x) ? a.x : b.x;
        hi_x = (c.x > hi_x) ? c.x : hi_x;
        lo_y = (a.y < b.y) ? a.y : b.y;
        lo_y = (c.y < lo_y) ? c.y : lo_y;
        hi_y = (a.y > b.y) ? a.y : b.y;
        hi_y = (c.y > hi_y) ? c.y : hi_y;
        area = edge_at(a, b, c.x, c.y);
        if (area <= 0 || area >= RECIP_SIZE || hi_x < 0 || lo_x > FB_W - 1 ||
            hi_y < 0 || lo_y > FB_H - 1) begin
            return 1'b0;
        end
        recip = (longint'(1) << RECIP_SHIFT) / area;
        za = a.z;
        zb = b.z;
        zc = c.z;
        npix = 0;
        // Strictly covered pixels always fall inside the clamped box
        for (int y = 0; y < FB_H; y++) begin
            for (int x = 0; x < FB_W; x++) begin
                w0 = edge_at(b, c, x, y);
                w1 = edge_at(c, a, x, y);
                w2 = edge_at(a, b, x, y);
                if (w0 > 0 && w1 > 0 && w2 > 0) begin
                    acc = (w0 * za + w1 * zb + w2 * zc) * recip;
                    exp_addr.push_back(y * FB_W + x);
                    exp_depth.push_back((acc >>> RECIP_SHIFT) & 64'hffff);
                    npix++;
                end
            end
        end
        exp_tri_pix.push_back(npix);
        return 1'b1;
    endfunction

    task automatic send_triangle(input vertex_t a, input vertex_t b, input vertex_t c);
        while (busy) begin
            @(posedge clk);
            #2;
        end
        x0 = a.x;
        y0 = a.y;
        z0 = a.z;
        x1 = b.x;
        y1 = b.y;
        z1 = b.z;
        x2 = c.x;
        y2 = c.y;
        z2 = c.z;
        tri_valid = 1'b1;
        if (model_triangle(a, b, c))
            drawn_exp++;
        else
            culled_exp++;
        sent++;
        @(posedge clk);
        #2;
        tri_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (busy || exp_tri_pix.size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic check_totals();
        check_value("culled pulses", culled_seen, culled_exp);
        check_value("tri_done pulses", done_seen, drawn_exp);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES)
            report_error("timeout, the run did not finish within the cycle limit");
    end

    // Compare at the falling edge, where DUT outputs are settled
    always @(negedge clk) begin
        if (!rst) begin
            if (dut.q_if.full)
                fifo_was_full = 1'b1;
            if (culled)
                culled_seen++;
            if (pix_write) begin
                if (exp_addr.size() == 0) begin
                    report_error("pixel write while no pixel was expected");
                end else begin
                    check_value("fb_addr", fb_addr, exp_addr.pop_front());
                    check_value("depth", depth, exp_depth.pop_front());
                    pix_in_tri++;
                end
            end
            if (tri_done) begin
                done_seen++;
                if (exp_tri_pix.size() == 0) begin
                    report_error("tri_done while no drawn triangle was outstanding");
                end else begin
                    check_value("pixels in triangle", pix_in_tri, exp_tri_pix.pop_front());
                    pix_in_tri = 0;
                end
            end
        end
    end

    initial begin
        vertex_t a, b, c;
        int seed_val;
        seed_val = $urandom(79);
        rst = 1'b1;
        tri_valid = 1'b0;
        x0 = '0;
        y0 = '0;
        z0 = '0;
        x1 = '0;
        y1 = '0;
        z1 = '0;
        x2 = '0;
        y2 = '0;
        z2 = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_value("busy after reset", busy, 0);
        check_value("culled after reset", culled, 0);
        check_value("pix_write after reset", pix_write, 0);
        check_value("tri_done after reset", tri_done, 0);
        @(posedge clk);
        #2;

        // Counter-clockwise triangle inside the tile
        send_triangle(make_vertex(2, 1, 1000), make_vertex(3, 7, 30000),
                      make_vertex(12, 2, 60000));
        wait_idle();
        check_value("tri_done after first triangle", done_seen, 1);
        check_totals();

        // Zero area, clockwise, outside the tile, area too large
        send_triangle(make_vertex(1, 1, 5), make_vertex(3, 3, 6), make_vertex(5, 5, 7));
        send_triangle(make_vertex(2, 1, 1000), make_vertex(12, 2, 60000),
                      make_vertex(3, 7, 30000));
        send_triangle(make_vertex(20, 1, 100), make_vertex(21, 7, 200), make_vertex(30, 2, 300));
        send_triangle(make_vertex(0, 0, 9), make_vertex(0, 100, 9), make_vertex(100, 0, 9));
        wait_idle();
        check_value("culled pulses after cull tests", culled_seen, 4);
        check_totals();

        // Crosses the tile on every side
        send_triangle(make_vertex(-5, -3, 500), make_vertex(2, 12, 40000),
                      make_vertex(22, 4, 20000));
        wait_idle();
        check_totals();

        for (int i = 0; i < NUM_RANDOM; i++) begin
            a = random_vertex();
            b = random_vertex();
            c = random_vertex();
            if (edge_at(a, b, c.x, c.y) < 0) begin
                send_triangle(a, c, b);
            end else begin
                send_triangle(a, b, c);
            end
        end
        wait_idle();
        check_value("fifo reached full", fifo_was_full, 1);
        check_value("tri_done plus culled pulses", done_seen + culled_seen, sent);
        check_totals();

        if (exp_addr.size() == 0 && exp_tri_pix.size() == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            report_error("expected pixels were left unmatched");
        end
    end

endmodule

`default_nettype wire
